/* ready_unit.f */
design/ready_pkg.sv
design/ready_xor_table.sv
design/ready_wakeup_bypass.sv
design/ready_operand_merge.sv
design/ready_unit_top.sv
tb/ready_unit_tb.sv

/* tb/ready_unit_tb.sv */
// Directed and LCG-driven checks against a bit model; valid write indices are kept distinct per cycle
module ready_unit_tb
  import ready_pkg::*;
;

  localparam int RAND_CYCLES   = 400;
  localparam int READY_TIMEOUT = 8;

  logic           clk_i = 1'b0;
  logic           arst_n_i;
  logic [1:0]     busy_vld;
  preg_t [1:0]    busy_idx;
  logic [3:0]     free_vld;
  preg_t [3:0]    free_idx;
  preg_t [3:0]    rd_idx;
  logic [3:0]     rd_rdy;

  // Next values, applied on the following rising edge
  logic [1:0]     stg_busy_vld;
  preg_t [1:0]    stg_busy_idx;
  logic [3:0]     stg_free_vld;
  preg_t [3:0]    stg_free_idx;
  preg_t [3:0]    stg_rd_idx;

  // Stored ready state as the table should hold it
  logic [NUM_PREGS-1:0] model_rdy;
  logic [31:0]          lcg_state;
  int                   checks;
  int                   errors;
  logic                 timed_out;

  always #5 clk_i = ~clk_i;

  ready_unit_top i_dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .busy0_vld_i (busy_vld[0]),
    .busy0_idx_i (busy_idx[0]),
    .busy1_vld_i (busy_vld[1]),
    .busy1_idx_i (busy_idx[1]),
    .free0_vld_i (free_vld[0]),
    .free0_idx_i (free_idx[0]),
    .free1_vld_i (free_vld[1]),
    .free1_idx_i (free_idx[1]),
    .free2_vld_i (free_vld[2]),
    .free2_idx_i (free_idx[2]),
    .free3_vld_i (free_vld[3]),
    .free3_idx_i (free_idx[3]),
    .rd0_idx_i   (rd_idx[0]),
    .rd1_idx_i   (rd_idx[1]),
    .rd2_idx_i   (rd_idx[2]),
    .rd3_idx_i   (rd_idx[3]),
    .rd0_rdy_o   (rd_rdy[0]),
    .rd1_rdy_o   (rd_rdy[1]),
    .rd2_rdy_o   (rd_rdy[2]),
    .rd3_rdy_o   (rd_rdy[3])
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Register 0 first, then same-cycle free, then same-cycle busy, then stored state
  function automatic logic expected_rdy(preg_t idx);
    logic rdy;
    rdy = model_rdy[idx];
    for (int b = 0; b < 2; b++) begin
      if (busy_vld[b] && busy_idx[b] == idx) begin
        rdy = 1'b0;
      end
    end
    for (int f = 0; f < 4; f++) begin
      if (free_vld[f] && free_idx[f] == idx) begin
        rdy = 1'b1;
      end
    end
    if (idx == '0) begin
      rdy = 1'b1;
    end
    return rdy;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("error t=%0t %s got %b expected %b", $time, name, got, exp);
      end
  endtask

  task automatic check_reads();
    logic exp;
    for (int r = 0; r < 4; r++) begin
      exp = expected_rdy(rd_idx[r]);
      checks++;
      assert (rd_rdy[r] === exp)
        else begin
          errors++;
          $display("error t=%0t rd%0d_rdy_o (index %0d) got %b expected %b",
                   $time, r, rd_idx[r], rd_rdy[r], exp);
        end
    end
  endtask

  // Same write rule as the table, busy to register 0 dropped
  task automatic update_model();
    for (int b = 0; b < 2; b++) begin
      if (busy_vld[b] && busy_idx[b] != '0) begin
        model_rdy[busy_idx[b]] = 1'b0;
      end
    end
    for (int f = 0; f < 4; f++) begin
      if (free_vld[f]) begin
        model_rdy[free_idx[f]] = 1'b1;
      end
    end
  endtask

  task automatic clear_stage();
    stg_busy_vld = '0;
    stg_busy_idx = '0;
    stg_free_vld = '0;
    stg_free_idx = '0;
    stg_rd_idx   = '0;
  endtask

  task automatic set_reads(input preg_t a, input preg_t b, input preg_t c, input preg_t d);
    stg_rd_idx[0] = a;
    stg_rd_idx[1] = b;
    stg_rd_idx[2] = c;
    stg_rd_idx[3] = d;
  endtask

  // Drive on the rising edge, check mid-cycle once the combinational reads settle
  task automatic apply_cycle();
    @(posedge clk_i);
    busy_vld <= stg_busy_vld;
    busy_idx <= stg_busy_idx;
    free_vld <= stg_free_vld;
    free_idx <= stg_free_idx;
    rd_idx   <= stg_rd_idx;
    @(negedge clk_i);
    check_reads();
    update_model();
  endtask

  task automatic init_inputs();
    arst_n_i  = 1'b0;
    busy_vld  = '0;
    busy_idx  = '0;
    free_vld  = '0;
    free_idx  = '0;
    rd_idx    = {preg_t'(4), preg_t'(3), preg_t'(2), preg_t'(1)};
    lcg_state = 32'hde25;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    clear_stage();
  endtask

  task automatic reset_dut();
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    model_rdy = '1;
  endtask

  task automatic wait_for_ready(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < READY_TIMEOUT && !ok; n++) begin
      @(negedge clk_i);
      if (arst_n_i && (&rd_rdy)) begin
        ok = 1'b1;
      end
    end
  endtask

  task automatic test_reset_ready();
    clear_stage();
    set_reads(0, 17, 42, 63);
    apply_cycle();
    set_reads(1, 31, 32, 62);
    apply_cycle();
  endtask

  // Every busy port paired with every free port, on its own register
  task automatic test_busy_free();
    preg_t r;
    for (int b = 0; b < 2; b++) begin
      for (int f = 0; f < 4; f++) begin
        r = preg_t'(8 + 4 * b + f);
        clear_stage();
        set_reads(r, 0, r, 63);
        stg_busy_vld[b] = 1'b1;
        stg_busy_idx[b] = r;
        apply_cycle();
        clear_stage();
        set_reads(r, 0, r, 63);
        apply_cycle();
        check_bit("rd0_rdy_o after busy", rd_rdy[0], 1'b0);
        stg_free_vld[f] = 1'b1;
        stg_free_idx[f] = r;
        apply_cycle();
        clear_stage();
        set_reads(r, 0, r, 63);
        apply_cycle();
        check_bit("rd0_rdy_o after free", rd_rdy[0], 1'b1);
      end
    end
  endtask

  task automatic test_free_bypass();
    clear_stage();
    set_reads(20, 21, 22, 0);
    stg_busy_vld = 2'b11;
    stg_busy_idx = {preg_t'(21), preg_t'(20)};
    apply_cycle();
    clear_stage();
    set_reads(20, 21, 22, 0);
    stg_free_vld[1] = 1'b1;
    stg_free_idx[1] = 20;
    stg_free_vld[2] = 1'b1;
    stg_free_idx[2] = 21;
    apply_cycle();
    check_bit("rd0_rdy_o freed same cycle", rd_rdy[0], 1'b1);
    check_bit("rd1_rdy_o freed same cycle", rd_rdy[1], 1'b1);
  endtask

  task automatic test_busy_claim();
    clear_stage();
    set_reads(30, 0, 31, 0);
    stg_busy_vld = 2'b11;
    stg_busy_idx = {preg_t'(0), preg_t'(30)};
    apply_cycle();
    check_bit("rd0_rdy_o claimed same cycle", rd_rdy[0], 1'b0);
    check_bit("rd1_rdy_o register 0 under busy", rd_rdy[1], 1'b1);
    clear_stage();
    set_reads(30, 0, 31, 0);
    apply_cycle();
    check_bit("rd0_rdy_o stored busy", rd_rdy[0], 1'b0);
    check_bit("rd1_rdy_o register 0 after busy", rd_rdy[1], 1'b1);
    stg_free_vld[0] = 1'b1;
    stg_free_idx[0] = 30;
    apply_cycle();
  endtask

  // Six distinct indices per cycle, reads often aimed at a write index
  task automatic test_random();
    logic [31:0]          rnd;
    logic [NUM_PREGS-1:0] used;
    preg_t                idx;
    preg_t                wr_idx [6];
    for (int c = 0; c < RAND_CYCLES; c++) begin
      clear_stage();
      used = '0;
      for (int p = 0; p < 6; p++) begin
        rnd = next_rand();
        idx = rnd[21:16];
        while (used[idx]) begin
          idx = idx + 1'b1;
        end
        used[idx] = 1'b1;
        wr_idx[p] = idx;
        if (p < 2) begin
          stg_busy_vld[p] = rnd[28] | rnd[29];
          stg_busy_idx[p] = idx;
        end else begin
          stg_free_vld[p - 2] = rnd[28];
          stg_free_idx[p - 2] = idx;
        end
      end
      for (int r = 0; r < 4; r++) begin
        rnd = next_rand();
        stg_rd_idx[r] = rnd[31] ? wr_idx[rnd[26:24] % 6] : preg_t'(rnd[21:16]);
      end
      apply_cycle();
    end
  endtask

  initial begin
    logic ok;
    init_inputs();
    reset_dut();
    wait_for_ready(ok);
    if (ok) begin
      test_reset_ready();
      test_busy_free();
      test_free_bypass();
      test_busy_claim();
      test_random();
    end else begin
      $display("ready outputs did not all read ready within %0d cycles after reset",
               READY_TIMEOUT);
      timed_out = 1'b1;
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* design/ready_unit_top.sv */
// No handshake; valid write ports must name distinct registers per cycle, reset leaves all ready
module ready_unit_top
  import ready_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  // Rename allocation
  input  logic  busy0_vld_i,
  input  preg_t busy0_idx_i,
  input  logic  busy1_vld_i,
  input  preg_t busy1_idx_i,
  // Writeback results
  input  logic  free0_vld_i,
  input  preg_t free0_idx_i,
  input  logic  free1_vld_i,
  input  preg_t free1_idx_i,
  input  logic  free2_vld_i,
  input  preg_t free2_idx_i,
  input  logic  free3_vld_i,
  input  preg_t free3_idx_i,
  // Issue operand lookups
  input  preg_t rd0_idx_i,
  input  preg_t rd1_idx_i,
  input  preg_t rd2_idx_i,
  input  preg_t rd3_idx_i,
  output logic  rd0_rdy_o,
  output logic  rd1_rdy_o,
  output logic  rd2_rdy_o,
  output logic  rd3_rdy_o
);

  // Stored state per read
  logic     rd0_table_rdy;
  logic     rd1_table_rdy;
  logic     rd2_table_rdy;
  logic     rd3_table_rdy;

  // Same-cycle write matches per read
  pending_e rd0_pending;
  pending_e rd1_pending;
  pending_e rd2_pending;
  pending_e rd3_pending;

  ready_xor_table i_table (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .busy0_vld_i (busy0_vld_i),
    .busy0_idx_i (busy0_idx_i),
    .busy1_vld_i (busy1_vld_i),
    .busy1_idx_i (busy1_idx_i),
    .free0_vld_i (free0_vld_i),
    .free0_idx_i (free0_idx_i),
    .free1_vld_i (free1_vld_i),
    .free1_idx_i (free1_idx_i),
    .free2_vld_i (free2_vld_i),
    .free2_idx_i (free2_idx_i),
    .free3_vld_i (free3_vld_i),
    .free3_idx_i (free3_idx_i),
    .rd0_idx_i   (rd0_idx_i),
    .rd1_idx_i   (rd1_idx_i),
    .rd2_idx_i   (rd2_idx_i),
    .rd3_idx_i   (rd3_idx_i),
    .rd0_rdy_o   (rd0_table_rdy),
    .rd1_rdy_o   (rd1_table_rdy),
    .rd2_rdy_o   (rd2_table_rdy),
    .rd3_rdy_o   (rd3_table_rdy)
  );

  ready_wakeup_bypass i_bypass (
    .free0_vld_i   (free0_vld_i),
    .free0_idx_i   (free0_idx_i),
    .free1_vld_i   (free1_vld_i),
    .free1_idx_i   (free1_idx_i),
    .free2_vld_i   (free2_vld_i),
    .free2_idx_i   (free2_idx_i),
    .free3_vld_i   (free3_vld_i),
    .free3_idx_i   (free3_idx_i),
    .busy0_vld_i   (busy0_vld_i),
    .busy0_idx_i   (busy0_idx_i),
    .busy1_vld_i   (busy1_vld_i),
    .busy1_idx_i   (busy1_idx_i),
    .rd0_idx_i     (rd0_idx_i),
    .rd1_idx_i     (rd1_idx_i),
    .rd2_idx_i     (rd2_idx_i),
    .rd3_idx_i     (rd3_idx_i),
    .rd0_pending_o (rd0_pending),
    .rd1_pending_o (rd1_pending),
    .rd2_pending_o (rd2_pending),
    .rd3_pending_o (rd3_pending)
  );

  ready_operand_merge i_merge (
    .rd0_idx_i       (rd0_idx_i),
    .rd1_idx_i       (rd1_idx_i),
    .rd2_idx_i       (rd2_idx_i),
    .rd3_idx_i       (rd3_idx_i),
    .rd0_table_rdy_i (rd0_table_rdy),
    .rd1_table_rdy_i (rd1_table_rdy),
    .rd2_table_rdy_i (rd2_table_rdy),
    .rd3_table_rdy_i (rd3_table_rdy),
    .rd0_pending_i   (rd0_pending),
    .rd1_pending_i   (rd1_pending),
    .rd2_pending_i   (rd2_pending),
    .rd3_pending_i   (rd3_pending),
    .rd0_rdy_o       (rd0_rdy_o),
    .rd1_rdy_o       (rd1_rdy_o),
    .rd2_rdy_o       (rd2_rdy_o),
    .rd3_rdy_o       (rd3_rdy_o)
  );

endmodule

/* design/ready_operand_merge.sv */
// Combinational priority merge; register 0 is treated as always ready on every read port
module ready_operand_merge
  import ready_pkg::*;
(
  // Read indices, needed only for the register 0 check
  input  preg_t    rd0_idx_i,
  input  preg_t    rd1_idx_i,
  input  preg_t    rd2_idx_i,
  input  preg_t    rd3_idx_i,
  // Stored state from the table
  input  logic     rd0_table_rdy_i,
  input  logic     rd1_table_rdy_i,
  input  logic     rd2_table_rdy_i,
  input  logic     rd3_table_rdy_i,
  // Same-cycle state from the bypass
  input  pending_e rd0_pending_i,
  input  pending_e rd1_pending_i,
  input  pending_e rd2_pending_i,
  input  pending_e rd3_pending_i,
  // Final operand ready to issue
  output logic     rd0_rdy_o,
  output logic     rd1_rdy_o,
  output logic     rd2_rdy_o,
  output logic     rd3_rdy_o
);

  // Priority: register 0, then freed, then claimed, then stored state
  function automatic logic merge_rdy(preg_t idx, logic table_rdy, pending_e pend);
    logic rdy;
    if (idx == '0) begin
      // Zero register never waits
      rdy = 1'b1;
    end else begin
      unique case (pend)
        // Writeback this cycle wins over the stale table bit
        PEND_FREED:   rdy = 1'b1;
        // Freshly renamed destination, value not produced yet
        PEND_CLAIMED: rdy = 1'b0;
        default:      rdy = table_rdy;
      endcase
    end
    return rdy;
  endfunction

  assign rd0_rdy_o = merge_rdy(rd0_idx_i, rd0_table_rdy_i, rd0_pending_i);
  assign rd1_rdy_o = merge_rdy(rd1_idx_i, rd1_table_rdy_i, rd1_pending_i);
  assign rd2_rdy_o = merge_rdy(rd2_idx_i, rd2_table_rdy_i, rd2_pending_i);
  assign rd3_rdy_o = merge_rdy(rd3_idx_i, rd3_table_rdy_i, rd3_pending_i);

endmodule

/* design/ready_wakeup_bypass.sv */
// Purely combinational; relies on valid write ports naming distinct registers in a cycle
module ready_wakeup_bypass
  import ready_pkg::*;
(
  // Free ports, same cycle
  input  logic     free0_vld_i,
  input  preg_t    free0_idx_i,
  input  logic     free1_vld_i,
  input  preg_t    free1_idx_i,
  input  logic     free2_vld_i,
  input  preg_t    free2_idx_i,
  input  logic     free3_vld_i,
  input  preg_t    free3_idx_i,
  // Busy ports, same cycle
  input  logic     busy0_vld_i,
  input  preg_t    busy0_idx_i,
  input  logic     busy1_vld_i,
  input  preg_t    busy1_idx_i,
  // Read indices from issue
  input  preg_t    rd0_idx_i,
  input  preg_t    rd1_idx_i,
  input  preg_t    rd2_idx_i,
  input  preg_t    rd3_idx_i,
  output pending_e rd0_pending_o,
  output pending_e rd1_pending_o,
  output pending_e rd2_pending_o,
  output pending_e rd3_pending_o
);

  localparam int NUM_RD = 4;

  preg_t    rd_idx   [NUM_RD];
  logic     free_hit [NUM_RD];
  logic     busy_hit [NUM_RD];
  pending_e pending  [NUM_RD];

  always_comb begin
    rd_idx[0] = rd0_idx_i;
    rd_idx[1] = rd1_idx_i;
    rd_idx[2] = rd2_idx_i;
    rd_idx[3] = rd3_idx_i;
  end

  always_comb begin
    for (int r = 0; r < NUM_RD; r++) begin
      // Any writeback landing on this operand now
      free_hit[r] = (free0_vld_i && (free0_idx_i == rd_idx[r])) ||
                    (free1_vld_i && (free1_idx_i == rd_idx[r])) ||
                    (free2_vld_i && (free2_idx_i == rd_idx[r])) ||
                    (free3_vld_i && (free3_idx_i == rd_idx[r]));
      // Any rename allocation of this operand now
      busy_hit[r] = (busy0_vld_i && (busy0_idx_i == rd_idx[r])) ||
                    (busy1_vld_i && (busy1_idx_i == rd_idx[r]));
      if (free_hit[r]) begin
        pending[r] = PEND_FREED;
      end else if (busy_hit[r]) begin
        pending[r] = PEND_CLAIMED;
      end else begin
        pending[r] = PEND_NONE;
      end
    end
  end

  // Both at once means a register was freed and reallocated in one cycle
  always_comb begin
    for (int r = 0; r < NUM_RD; r++) begin
      a_no_dual_hit: assert final (!(free_hit[r] && busy_hit[r]))
        else $error("read %0d index %0d hit by free and busy ports", r, rd_idx[r]);
    end
  end

  assign rd0_pending_o = pending[0];
  assign rd1_pending_o = pending[1];
  assign rd2_pending_o = pending[2];
  assign rd3_pending_o = pending[3];

endmodule

/* design/ready_xor_table.sv */
// Valid write ports must carry distinct indices each cycle; busy writes to register 0 are dropped
module ready_xor_table
  import ready_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  // Busy ports from rename
  input  logic  busy0_vld_i,
  input  preg_t busy0_idx_i,
  input  logic  busy1_vld_i,
  input  preg_t busy1_idx_i,
  // Free ports from writeback
  input  logic  free0_vld_i,
  input  preg_t free0_idx_i,
  input  logic  free1_vld_i,
  input  preg_t free1_idx_i,
  input  logic  free2_vld_i,
  input  preg_t free2_idx_i,
  input  logic  free3_vld_i,
  input  preg_t free3_idx_i,
  // Read ports, stored state only
  input  preg_t rd0_idx_i,
  input  preg_t rd1_idx_i,
  input  preg_t rd2_idx_i,
  input  preg_t rd3_idx_i,
  output logic  rd0_rdy_o,
  output logic  rd1_rdy_o,
  output logic  rd2_rdy_o,
  output logic  rd3_rdy_o
);

  localparam int NUM_WR = 6;

  // Target state per port, bit 0 is busy0 and bit 5 is free3
  // Busy ports write 0, free ports write 1
  localparam logic [NUM_WR-1:0] WR_VAL = 6'b111100;

  // Port view in order busy0, busy1, free0 .. free3
  logic  port_vld [NUM_WR];
  preg_t port_idx [NUM_WR];
  logic  wr_en    [NUM_WR];

  // One single-write bank per port
  logic [NUM_PREGS-1:0] bank_q [NUM_WR];

  // Ready state of every register, XOR across the banks
  logic [NUM_PREGS-1:0] state;

  always_comb begin
    port_vld[0] = busy0_vld_i;
    port_idx[0] = busy0_idx_i;
    port_vld[1] = busy1_vld_i;
    port_idx[1] = busy1_idx_i;
    port_vld[2] = free0_vld_i;
    port_idx[2] = free0_idx_i;
    port_vld[3] = free1_vld_i;
    port_idx[3] = free1_idx_i;
    port_vld[4] = free2_vld_i;
    port_idx[4] = free2_idx_i;
    port_vld[5] = free3_vld_i;
    port_idx[5] = free3_idx_i;
  end

  // Register 0 is hard ready, so busy writes to it never reach a bank
  always_comb begin
    for (int p = 0; p < NUM_WR; p++) begin
      wr_en[p] = port_vld[p] && (WR_VAL[p] || (port_idx[p] != '0));
    end
  end

  always_comb begin
    state = '0;
    for (int b = 0; b < NUM_WR; b++) begin
      state ^= bank_q[b];
    end
  end

  // Bank b takes the bit that makes the full XOR land on WR_VAL[b]
  // Own bit cancels out of state, leaving the XOR of the other five banks
  for (genvar b = 0; b < NUM_WR; b++) begin : g_bank
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        // All ready after reset, carried by bank 0 alone
        bank_q[b] <= (b == 0) ? {NUM_PREGS{1'b1}} : {NUM_PREGS{1'b0}};
      end else if (wr_en[b]) begin
        bank_q[b][port_idx[b]] <= WR_VAL[b] ^ state[port_idx[b]] ^ bank_q[b][port_idx[b]];
      end
    end
  end

  // Plain lookups, same-cycle writes are not visible here
  assign rd0_rdy_o = state[rd0_idx_i];
  assign rd1_rdy_o = state[rd1_idx_i];
  assign rd2_rdy_o = state[rd2_idx_i];
  assign rd3_rdy_o = state[rd3_idx_i];

  // Two ports on one register would leave two banks fighting over that entry
  for (genvar i = 0; i < NUM_WR; i++) begin : g_chk_i
    for (genvar j = i + 1; j < NUM_WR; j++) begin : g_chk_j
      a_distinct_idx: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (port_vld[i] && port_vld[j]) |-> (port_idx[i] != port_idx[j])
      ) else $error("write ports %0d and %0d share index %0d", i, j, port_idx[i]);
    end
  end

endmodule

/* design/ready_pkg.sv */
// Register count is fixed at 64 here and the index width is derived from it; no module overrides
package ready_pkg;

  // Physical register file size seen by rename and issue
  localparam int NUM_PREGS = 64;

  // Index width, 6 bits for 64 registers
  localparam int PREG_W = $clog2(NUM_PREGS);

  // One physical register index
  typedef logic [PREG_W-1:0] preg_t;

  // Same-cycle state of one read port
  // Freed means a free port targets the read index in this cycle
  // Claimed means a busy port targets it in this cycle
  typedef enum logic [1:0] {
    PEND_NONE    = 2'b00,
    PEND_FREED   = 2'b01,
    PEND_CLAIMED = 2'b10
  } pending_e;

endpackage
